// ==== rtl/bf_pkg.sv ====
`default_nettype none

package bf_pkg;

    // processing controller
    typedef enum logic [1:0] {
        S_IDLE = 2'd0,      // waiting for start
        S_FILL = 2'd1,      // delay lines filling up
        S_RUN  = 2'd2       // sweeping beams every sample
    } ctrl_state_e;

    // displayed beam level
    localparam int LEVEL_W = 8;

    typedef logic [LEVEL_W-1:0] level_t;   // unsigned, 0 = silent

endpackage : bf_pkg

`default_nettype wire

// ==== rtl/i2s_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2s_capture #(
    parameter int N_MIC    = 4,
    parameter int SAMPLE_W = 16
) (
    input  wire                        i_50M_clk,
    input  wire                        i_rst,
    input  wire                        i_bclk,
    input  wire                        i_lrck,
    input  wire  [N_MIC-1:0]           i_mic_data,
    output logic [N_MIC*SAMPLE_W-1:0]  o_samples,
    output logic                       o_sample_valid
);

    localparam int CNT_W = $clog2(SAMPLE_W + 2);

    logic [2:0]          bclk_s;    // [1] synced, [2] edge history
    logic [2:0]          lrck_s;
    logic [N_MIC-1:0]    data_s1;
    logic [N_MIC-1:0]    data_s2;
    logic [CNT_W-1:0]    bit_cnt_r;
    logic [SAMPLE_W-1:0] shift_r [N_MIC];
    logic                bclk_rise;
    logic                lrck_fall;
    logic                cnt_step;
    logic                take_bit;
    logic                last_bit;

    assign bclk_rise = bclk_s[1] & ~bclk_s[2];
    assign lrck_fall = ~lrck_s[1] & lrck_s[2];

    // rise 0 after the LRCK fall is the dummy slot, then MSB first
    assign cnt_step = bclk_rise & ~lrck_s[1] & (bit_cnt_r <= CNT_W'(SAMPLE_W));
    assign take_bit = cnt_step & (bit_cnt_r != '0);
    assign last_bit = cnt_step & (bit_cnt_r == CNT_W'(SAMPLE_W));

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            bclk_s         <= '0;
            lrck_s         <= '1;
            data_s1        <= '0;
            data_s2        <= '0;
            bit_cnt_r      <= CNT_W'(SAMPLE_W + 1);   // idle until first LRCK fall
            o_sample_valid <= 1'b0;
        end else begin
            bclk_s         <= {bclk_s[1:0], i_bclk};
            lrck_s         <= {lrck_s[1:0], i_lrck};
            data_s1        <= i_mic_data;
            data_s2        <= data_s1;
            o_sample_valid <= last_bit;
            if (lrck_fall) begin
                bit_cnt_r <= '0;
            end else if (cnt_step) begin
                bit_cnt_r <= bit_cnt_r + 1'b1;
            end
        end
    end

    always_ff @(posedge i_50M_clk) begin
        for (int m = 0; m < N_MIC; m++) begin
            if (take_bit) begin
                shift_r[m] <= {shift_r[m][SAMPLE_W-2:0], data_s2[m]};
            end
            if (last_bit) begin
                o_samples[m*SAMPLE_W +: SAMPLE_W] <= {shift_r[m][SAMPLE_W-2:0], data_s2[m]};
            end
        end
    end

    // left channel only, so the pulse lands while LRCK is still low
    a_valid_left: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        o_sample_valid |-> !lrck_s[1])
        else $error("sample_valid while LRCK high");

endmodule : i2s_capture

`default_nettype wire

// ==== rtl/delay_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module delay_bank #(
    parameter int N_MIC    = 4,
    parameter int SAMPLE_W = 16,
    parameter int GRID_X   = 8
) (
    input  wire                          i_50M_clk,
    input  wire                          i_rst,
    input  wire   [N_MIC*SAMPLE_W-1:0]   i_samples,
    input  wire                          i_sample_valid,
    input  wire                          i_rd_en,
    input  wire   [$clog2(GRID_X)-1:0]   i_rd_beam,
    output logic  [N_MIC*SAMPLE_W-1:0]   o_taps
);

    localparam int MAX_DELAY = (N_MIC - 1) * GRID_X / 2;
    localparam int AW        = $clog2(MAX_DELAY + 1);
    localparam int DEPTH     = 1 << AW;             // power of two above MAX_DELAY
    localparam int HALF      = GRID_X / 2;

    logic [SAMPLE_W-1:0] ring_r [N_MIC][DEPTH];
    logic [AW-1:0]       wr_ptr_r;
    logic [AW-1:0]       rd_addr [N_MIC];

    // tap address per mic, counted back from the newest sample
    always_comb begin
        int mag;
        int dly;
        for (int m = 0; m < N_MIC; m++) begin
            if (int'(i_rd_beam) >= HALF) begin
                mag = int'(i_rd_beam) - HALF;       // slope >= 0
                dly = m * mag;
            end else begin
                mag = HALF - int'(i_rd_beam);       // negative slope
                dly = (N_MIC - 1 - m) * mag;
            end
            rd_addr[m] = wr_ptr_r - AW'(1) - AW'(dly);
        end
    end

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            wr_ptr_r <= '0;
        end else if (i_sample_valid) begin
            wr_ptr_r <= wr_ptr_r + 1'b1;
        end
    end

    always_ff @(posedge i_50M_clk) begin
        for (int m = 0; m < N_MIC; m++) begin
            if (i_sample_valid) begin
                ring_r[m][wr_ptr_r] <= i_samples[m*SAMPLE_W +: SAMPLE_W];
            end
            if (i_rd_en) begin
                o_taps[m*SAMPLE_W +: SAMPLE_W] <= ring_r[m][rd_addr[m]];
            end
        end
    end

    // sweep must never overlap a write, the pointer would move under it
    a_no_rw_overlap: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        !(i_rd_en && i_sample_valid))
        else $error("read during sample write");

endmodule : delay_bank

`default_nettype wire

// ==== rtl/beam_power.sv ====
`timescale 1ns/1ps
`default_nettype none

module beam_power
    import bf_pkg::*;
#(
    parameter int N_MIC    = 4,
    parameter int SAMPLE_W = 16,
    parameter int GRID_X   = 8,
    parameter int BLOCK_L  = 32
) (
    input  wire                          i_50M_clk,
    input  wire                          i_rst,
    input  wire                          i_start,
    input  wire                          i_sample_valid,
    input  wire   [N_MIC*SAMPLE_W-1:0]   i_taps,
    output logic                         o_rd_en,
    output logic  [$clog2(GRID_X)-1:0]   o_rd_beam,
    output logic                         o_acc_valid,
    output logic  [$clog2(GRID_X)-1:0]   o_acc_idx,
    output logic  [2*(SAMPLE_W+$clog2(N_MIC))+$clog2(BLOCK_L)-1:0] o_acc_energy,
    output logic                         o_frame_done
);

    localparam int BW        = $clog2(GRID_X);
    localparam int SUM_W     = SAMPLE_W + $clog2(N_MIC);
    localparam int SQ_W      = 2 * SUM_W;
    localparam int ACC_W     = SQ_W + $clog2(BLOCK_L);
    localparam int MAX_DELAY = (N_MIC - 1) * GRID_X / 2;
    localparam int FILL_W    = $clog2(MAX_DELAY + 1);
    localparam int BLK_W     = $clog2(BLOCK_L);

    ctrl_state_e              state_r, state_w;
    logic [FILL_W-1:0]        fill_cnt_r, fill_cnt_w;
    logic [BLK_W-1:0]         blk_cnt_r;
    logic                     last_r;           // sweep in flight closes the block
    logic                     tap_vld_r;
    logic [BW-1:0]            tap_beam_r;
    logic                     sum_vld_r;
    logic [BW-1:0]            sum_beam_r;
    logic signed [SUM_W-1:0]  tap_sum;
    logic signed [SUM_W-1:0]  sum_r;
    logic signed [SQ_W-1:0]   sq;
    logic [ACC_W-1:0]         acc_r [GRID_X];
    logic                     dump_r;
    logic [BW-1:0]            dump_idx_r;
    logic                     sweep_start;
    logic                     sum_done;
    logic                     busy;

    always_comb begin
        state_w    = state_r;
        fill_cnt_w = fill_cnt_r;
        case (state_r)
            S_IDLE: begin
                if (i_start) state_w = S_FILL;
            end
            S_FILL: begin
                if (i_sample_valid) begin
                    if (fill_cnt_r == FILL_W'(MAX_DELAY)) state_w = S_RUN;
                    else fill_cnt_w = fill_cnt_r + 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign sweep_start = (state_r == S_RUN) && i_sample_valid;
    assign sum_done    = sum_vld_r && (sum_beam_r == BW'(GRID_X - 1)) && last_r;
    assign busy        = o_rd_en | tap_vld_r | sum_vld_r | dump_r;

    always_comb begin
        tap_sum = '0;
        for (int m = 0; m < N_MIC; m++) begin
            tap_sum = tap_sum + SUM_W'($signed(i_taps[m*SAMPLE_W +: SAMPLE_W]));
        end
    end

    assign sq = sum_r * sum_r;

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            state_r      <= S_IDLE;
            fill_cnt_r   <= '0;
            blk_cnt_r    <= '0;
            last_r       <= 1'b0;
            o_rd_en      <= 1'b0;
            o_rd_beam    <= '0;
            tap_vld_r    <= 1'b0;
            tap_beam_r   <= '0;
            sum_vld_r    <= 1'b0;
            sum_beam_r   <= '0;
            dump_r       <= 1'b0;
            dump_idx_r   <= '0;
            o_frame_done <= 1'b0;
        end else begin
            state_r    <= state_w;
            fill_cnt_r <= fill_cnt_w;
            if (sweep_start) begin               // address stage
                o_rd_en   <= 1'b1;
                o_rd_beam <= '0;
                last_r    <= (blk_cnt_r == BLK_W'(BLOCK_L - 1));
                blk_cnt_r <= (blk_cnt_r == BLK_W'(BLOCK_L - 1)) ? '0 : blk_cnt_r + 1'b1;
            end else if (o_rd_en) begin
                if (o_rd_beam == BW'(GRID_X - 1)) o_rd_en <= 1'b0;
                else o_rd_beam <= o_rd_beam + 1'b1;
            end
            tap_vld_r  <= o_rd_en;
            tap_beam_r <= o_rd_beam;
            sum_vld_r  <= tap_vld_r;
            sum_beam_r <= tap_beam_r;
            if (sum_done) begin
                last_r     <= 1'b0;
                dump_r     <= 1'b1;
                dump_idx_r <= '0;
            end else if (dump_r) begin
                if (dump_idx_r == BW'(GRID_X - 1)) dump_r <= 1'b0;
                else dump_idx_r <= dump_idx_r + 1'b1;
            end
            o_frame_done <= dump_r && (dump_idx_r == BW'(GRID_X - 1));
        end
    end

    always_ff @(posedge i_50M_clk) begin
        if (tap_vld_r) sum_r <= tap_sum;   // sum stage
    end

    // square-accumulate, cleared beam by beam as it is dumped
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int g = 0; g < GRID_X; g++) acc_r[g] <= '0;
        end else if (sum_vld_r) begin
            acc_r[sum_beam_r] <= acc_r[sum_beam_r] + ACC_W'($unsigned(sq));
        end else if (dump_r) begin
            acc_r[dump_idx_r] <= '0;
        end
    end

    assign o_acc_valid  = dump_r;
    assign o_acc_idx    = dump_idx_r;
    assign o_acc_energy = acc_r[dump_idx_r];

    // capture side has to leave the sweep and dump time to finish
    a_sweep_idle: assert property (@(posedge i_50M_clk) disable iff (i_rst)
        i_sample_valid |-> !busy)
        else $error("sample pulse during sweep (state %s)", state_r.name());

endmodule : beam_power

`default_nettype wire

// ==== rtl/beam_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module beam_map
    import bf_pkg::*;
#(
    parameter int GRID_X      = 8,
    parameter int LEVEL_SHIFT = 30,
    parameter int ENERGY_W    = 41
) (
    input  wire                         i_50M_clk,
    input  wire                         i_rst,
    input  wire                         i_acc_valid,
    input  wire  [$clog2(GRID_X)-1:0]   i_acc_idx,
    input  wire  [ENERGY_W-1:0]         i_acc_energy,
    output logic [$clog2(GRID_X)-1:0]   o_pix_idx,
    output level_t                      o_pix_level,
    output logic                        o_line_start
);

    localparam int BW = $clog2(GRID_X);

    logic [ENERGY_W-1:0] shifted;
    level_t              level_new;
    level_t              levels_r [GRID_X];

    assign shifted = i_acc_energy >> LEVEL_SHIFT;

    // clip anything above the top level
    assign level_new = (shifted[ENERGY_W-1:LEVEL_W] != '0) ? {LEVEL_W{1'b1}}
                                                           : shifted[LEVEL_W-1:0];

    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            for (int g = 0; g < GRID_X; g++) levels_r[g] <= '0;
        end else if (i_acc_valid) begin
            levels_r[i_acc_idx] <= level_new;
        end
    end

    // free-running scanner, one beam per clock
    always_ff @(posedge i_50M_clk or posedge i_rst) begin
        if (i_rst) begin
            o_pix_idx <= '0;
        end else if (o_pix_idx == BW'(GRID_X - 1)) begin
            o_pix_idx <= '0;
        end else begin
            o_pix_idx <= o_pix_idx + 1'b1;
        end
    end

    assign o_pix_level  = levels_r[o_pix_idx];
    assign o_line_start = (o_pix_idx == '0);

endmodule : beam_map

`default_nettype wire

// ==== rtl/beamform_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module beamform_top
    import bf_pkg::*;
#(
    parameter int N_MIC       = 4,
    parameter int SAMPLE_W    = 16,
    parameter int GRID_X      = 8,
    parameter int BLOCK_L     = 32,
    parameter int LEVEL_SHIFT = 30
) (
    input  wire                        i_50M_clk,
    input  wire                        i_rst,
    input  wire                        i_start,
    input  wire                        i_bclk,
    input  wire                        i_lrck,
    input  wire  [N_MIC-1:0]           i_mic_data,
    output logic [$clog2(GRID_X)-1:0]  o_pix_idx,
    output level_t                     o_pix_level,
    output logic                       o_line_start,
    output logic                       o_frame_done
);

    // same width as the accumulators inside beam_power
    localparam int ENERGY_W = 2 * (SAMPLE_W + $clog2(N_MIC)) + $clog2(BLOCK_L);

    logic [N_MIC*SAMPLE_W-1:0] samples;
    logic                      sample_valid;
    logic                      rd_en;
    logic [$clog2(GRID_X)-1:0] rd_beam;
    logic [N_MIC*SAMPLE_W-1:0] taps;
    logic                      acc_valid;
    logic [$clog2(GRID_X)-1:0] acc_idx;
    logic [ENERGY_W-1:0]       acc_energy;

    i2s_capture #(.N_MIC(N_MIC), .SAMPLE_W(SAMPLE_W)) u_i2s_capture (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst),
        .i_bclk(i_bclk), .i_lrck(i_lrck), .i_mic_data(i_mic_data),
        .o_samples(samples), .o_sample_valid(sample_valid)
    );

    delay_bank #(.N_MIC(N_MIC), .SAMPLE_W(SAMPLE_W), .GRID_X(GRID_X)) u_delay_bank (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst),
        .i_samples(samples), .i_sample_valid(sample_valid),
        .i_rd_en(rd_en), .i_rd_beam(rd_beam), .o_taps(taps)
    );

    beam_power #(
        .N_MIC(N_MIC), .SAMPLE_W(SAMPLE_W), .GRID_X(GRID_X), .BLOCK_L(BLOCK_L)
    ) u_beam_power (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst), .i_start(i_start),
        .i_sample_valid(sample_valid), .i_taps(taps),
        .o_rd_en(rd_en), .o_rd_beam(rd_beam),
        .o_acc_valid(acc_valid), .o_acc_idx(acc_idx), .o_acc_energy(acc_energy),
        .o_frame_done(o_frame_done)
    );

    beam_map #(.GRID_X(GRID_X), .LEVEL_SHIFT(LEVEL_SHIFT), .ENERGY_W(ENERGY_W)) u_beam_map (
        .i_50M_clk(i_50M_clk), .i_rst(i_rst),
        .i_acc_valid(acc_valid), .i_acc_idx(acc_idx), .i_acc_energy(acc_energy),
        .o_pix_idx(o_pix_idx), .o_pix_level(o_pix_level), .o_line_start(o_line_start)
    );

endmodule : beamform_top

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS  = 20,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0;   // release away from the active edge
    end

endmodule : tb_clock

`default_nettype wire

// ==== tests/tb_beamform.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_beamform
    import bf_pkg::*;
();

    localparam int N_MIC        = 4;
    localparam int SAMPLE_W     = 16;
    localparam int GRID_X       = 8;
    localparam int BLOCK_L      = 32;
    localparam int LEVEL_SHIFT  = 30;
    localparam int BW           = $clog2(GRID_X);
    localparam int MAX_DELAY    = (N_MIC - 1) * GRID_X / 2;
    localparam int BCLK_HALF    = 4;                       // 8 clocks per BCLK
    localparam int FRAME_CLKS   = 2 * (SAMPLE_W + 1) * 2 * BCLK_HALF;
    localparam int IDLE_FRAMES  = 3;
    localparam int TOTAL_FRAMES = IDLE_FRAMES + MAX_DELAY + 1 + 6 * BLOCK_L;
    localparam int TIMEOUT_CYC  = 2 * TOTAL_FRAMES * FRAME_CLKS + 1000;
    localparam int PAT_DC       = 0;
    localparam int PAT_RANDOM   = 1;
    localparam int PAT_PULSE    = 2;
    localparam int STEER_BEAM   = 6;
    localparam int PULSE_GAP    = 16;
    localparam int DC_SMALL     = 12000;
    localparam int DC_LARGE     = -32768;
    localparam int PULSE_AMP    = 30000;

    logic                        clk_50m;
    logic                        rst;
    logic                        start;
    logic                        bclk;
    logic                        lrck;
    logic [N_MIC-1:0]            mic_data;
    logic [BW-1:0]               pix_idx;
    level_t                      pix_level;
    logic                        line_start;
    logic                        frame_done;
    ctrl_state_e                 model_state;
    int                          model_fill;
    int                          model_blk;
    int                          n_frames;
    logic signed [SAMPLE_W-1:0]  hist [N_MIC][TOTAL_FRAMES + 8];
    longint                      acc_model [GRID_X];
    level_t                      exp_level [GRID_X];
    level_t                      line_lvl [GRID_X];
    int                          err_cnt;
    int                          chk_cnt;
    int                          cycle_cnt;
    int                          seed;
    int                          done_cnt = 0;

    tb_clock #(.PERIOD_NS(20), .RST_CYCLES(8)) u_tb_clock (.o_clk(clk_50m), .o_rst(rst));

    beamform_top #(
        .N_MIC(N_MIC), .SAMPLE_W(SAMPLE_W), .GRID_X(GRID_X),
        .BLOCK_L(BLOCK_L), .LEVEL_SHIFT(LEVEL_SHIFT)
    ) u_beamform_top (
        .i_50M_clk(clk_50m), .i_rst(rst), .i_start(start),
        .i_bclk(bclk), .i_lrck(lrck), .i_mic_data(mic_data),
        .o_pix_idx(pix_idx), .o_pix_level(pix_level),
        .o_line_start(line_start), .o_frame_done(frame_done)
    );

    always @(negedge clk_50m) begin
        if (frame_done) done_cnt <= done_cnt + 1;
    end

    task automatic check_level(input string name, input level_t got, input level_t exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input logic [BW-1:0] got,
                               input logic [BW-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("** Error: %s = %h, expected %h", name, got, exp);
        end
    endtask

    function automatic int tap_delay(input int beam, input int mic);
        int slope;
        slope = beam - GRID_X / 2;
        if (slope >= 0) return mic * slope;
        return (N_MIC - 1 - mic) * (-slope);
    endfunction

    function automatic level_t level_of(input longint energy);
        longint shifted;
        shifted = energy >> LEVEL_SHIFT;
        if (shifted > (1 << LEVEL_W) - 1) return level_t'((1 << LEVEL_W) - 1);
        return level_t'(shifted);
    endfunction

    // reference model, one call per frame sent
    task automatic model_frame(input logic [N_MIC*SAMPLE_W-1:0] smp);
        longint beam_sum;
        for (int m = 0; m < N_MIC; m++) begin
            hist[m][n_frames] = smp[m*SAMPLE_W +: SAMPLE_W];
        end
        n_frames++;
        if (model_state == S_FILL) begin
            model_fill++;
            if (model_fill == MAX_DELAY + 1) model_state = S_RUN;
        end else if (model_state == S_RUN) begin
            for (int b = 0; b < GRID_X; b++) begin
                beam_sum = 0;
                for (int m = 0; m < N_MIC; m++) begin
                    beam_sum += longint'(hist[m][n_frames - 1 - tap_delay(b, m)]);
                end
                acc_model[b] += beam_sum * beam_sum;
            end
            model_blk++;
            if (model_blk == BLOCK_L) begin
                for (int b = 0; b < GRID_X; b++) begin
                    exp_level[b] = level_of(acc_model[b]);
                    acc_model[b] = 0;
                end
                model_blk = 0;
            end
        end
    endtask

    // left half carries a dummy slot then MSB first, right half is silent
    task automatic send_frame(input logic [N_MIC*SAMPLE_W-1:0] smp);
        for (int p = 0; p < 2 * (SAMPLE_W + 1); p++) begin
            @(negedge clk_50m);
            bclk = 1'b0;
            lrck = (p > SAMPLE_W);
            for (int m = 0; m < N_MIC; m++) begin
                mic_data[m] = (p >= 1 && p <= SAMPLE_W) ? smp[m*SAMPLE_W + SAMPLE_W - p] : 1'b0;
            end
            repeat (BCLK_HALF) @(negedge clk_50m);
            bclk = 1'b1;
            repeat (BCLK_HALF - 1) @(negedge clk_50m);
        end
        model_frame(smp);
    endtask

    // two scan lines back to back, keeps the levels of the first
    task automatic capture_line();
        int guard;
        guard = 0;
        @(negedge clk_50m);
        while (!line_start && guard < GRID_X) begin
            @(negedge clk_50m);
            guard++;
        end
        if (!line_start) begin
            err_cnt++;
            $display("o_line_start did not rise within one scan line");
        end
        for (int g = 0; g < 2 * GRID_X; g++) begin
            check_index("o_pix_idx", pix_idx, BW'(g % GRID_X));
            check_flag("o_line_start", line_start, (g % GRID_X) == 0);
            if (g < GRID_X) line_lvl[g] = pix_level;
            @(negedge clk_50m);
        end
    endtask

    task automatic compare_line();
        for (int g = 0; g < GRID_X; g++) begin
            check_level($sformatf("o_pix_level[%0d]", g), line_lvl[g], exp_level[g]);
        end
    endtask

    task automatic send_block(input int kind, input int amp);
        logic [N_MIC*SAMPLE_W-1:0] smp;
        int                        target;
        int                        waited;
        target = done_cnt + 1;
        waited = 0;
        for (int k = 0; k < BLOCK_L; k++) begin
            for (int m = 0; m < N_MIC; m++) begin
                if (kind == PAT_RANDOM) begin
                    smp[m*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'($random(seed));
                end else if (kind == PAT_PULSE) begin
                    smp[m*SAMPLE_W +: SAMPLE_W] =
                        ((k + tap_delay(STEER_BEAM, m)) % PULSE_GAP == PULSE_GAP - 1)
                        ? SAMPLE_W'(amp) : '0;
                end else begin
                    smp[m*SAMPLE_W +: SAMPLE_W] = SAMPLE_W'(amp);
                end
            end
            send_frame(smp);
        end
        while (done_cnt < target && waited < FRAME_CLKS) begin
            @(negedge clk_50m);
            waited++;
        end
        if (done_cnt != target) begin
            err_cnt++;
            $display("o_frame_done pulsed %0d times, expected %0d", done_cnt, target);
        end
        capture_line();
    endtask

    task automatic test_idle();
        logic [N_MIC*SAMPLE_W-1:0] smp;
        $display("idle test, model controller in %s", model_state.name());
        for (int f = 0; f < IDLE_FRAMES; f++) begin
            smp = {$random(seed), $random(seed)};
            send_frame(smp);
        end
        repeat (4 * GRID_X) @(negedge clk_50m);
        check_flag("o_frame_done", done_cnt != 0, 1'b0);
        capture_line();
        for (int g = 0; g < GRID_X; g++) begin
            check_level($sformatf("o_pix_level[%0d]", g), line_lvl[g], level_t'(0));
        end
    endtask

    task automatic test_uniform();
        level_t dc_level;
        @(negedge clk_50m);
        start       = 1'b1;
        model_state = S_FILL;
        for (int f = 0; f <= MAX_DELAY; f++) send_frame({N_MIC{SAMPLE_W'(DC_SMALL)}});
        $display("fill sent, model controller in %s", model_state.name());
        dc_level = level_of(longint'(BLOCK_L) * longint'(N_MIC * DC_SMALL)
                            * longint'(N_MIC * DC_SMALL));
        send_block(PAT_DC, DC_SMALL);
        compare_line();
        for (int g = 0; g < GRID_X; g++) begin
            check_level($sformatf("o_pix_level[%0d]", g), line_lvl[g], dc_level);
        end
        send_block(PAT_DC, DC_LARGE);   // far past the top level
        compare_line();
        for (int g = 0; g < GRID_X; g++) begin
            check_level($sformatf("o_pix_level[%0d]", g), line_lvl[g], level_t'(8'hFF));
        end
    endtask

    task automatic test_steering();
        send_block(PAT_DC, 0);          // quiet block flushes the DC history
        compare_line();
        send_block(PAT_PULSE, PULSE_AMP);
        compare_line();
        for (int g = 0; g < GRID_X; g++) begin
            if (g != STEER_BEAM && line_lvl[g] >= line_lvl[STEER_BEAM]) begin
                err_cnt++;
                $display("beam %0d level %0d is not below steered beam %0d level %0d",
                         g, line_lvl[g], STEER_BEAM, line_lvl[STEER_BEAM]);
            end
        end
    endtask

    task automatic test_random();
        for (int n = 0; n < 2; n++) begin
            send_block(PAT_RANDOM, 0);
            compare_line();
        end
    endtask

    initial begin : watchdog
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYC) begin
            @(posedge clk_50m);
            cycle_cnt++;
        end
        $display("timeout, run still busy after %0d clocks", TIMEOUT_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        seed        = 13570;
        err_cnt     = 0;
        chk_cnt     = 0;
        start       = 1'b0;
        bclk        = 1'b0;
        lrck        = 1'b1;
        mic_data    = '0;
        model_state = S_IDLE;
        model_fill  = 0;
        model_blk   = 0;
        n_frames    = 0;
        for (int g = 0; g < GRID_X; g++) begin
            acc_model[g] = 0;
            exp_level[g] = '0;
        end
        while (rst !== 1'b0) @(negedge clk_50m);
        repeat (2) @(negedge clk_50m);
        test_idle();
        test_uniform();
        test_steering();
        test_random();
        $display("done, %0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule : tb_beamform

`default_nettype wire

// ==== src.f ====
rtl/bf_pkg.sv
rtl/i2s_capture.sv
rtl/delay_bank.sv
rtl/beam_power.sv
rtl/beam_map.sv
rtl/beamform_top.sv
tests/tb_clock.sv
tests/tb_beamform.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f src.f --top-module tb_beamform -o tb_beamform_sim

out=$(./obj_dir/tb_beamform_sim)
echo "$out"

echo "$out" | grep -q "^PASS: all tests$"
